// ==== all.f ====
common/i2si_audio_pkg.sv
common/i2si_ctrl_pkg.sv
verilog/i2si_sync.sv
deserializer/i2si_deserializer.sv
bist/i2si_bist_gen.sv
verilog/i2si_merge.sv
verilog/i2si_fifo.sv
verilog/i2s_in.sv
sim/i2s_tx_model.sv
sim/tb_i2s_in.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_i2s_in
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Checks failed
PASS_MSG  ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/tb_i2s_in.sv ====
module tb_i2s_in
    import i2si_audio_pkg::*;
    import i2si_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period      = 40;
    localparam int fifo_depth_log2 = 3;
    localparam int sync_stages     = 2;
    localparam int fifo_depth      = 2 ** fifo_depth_log2;
    localparam int sck_half        = 4;
    localparam int pad_bits        = sample_width - bist_val_width;
    localparam int settle_cycles   = sync_stages + 4;   // Sync, edge detect, valid, FIFO flag

    localparam logic [bist_val_width-1:0] ramp_start = 12'h100;
    localparam logic [bist_inc_width-1:0] ramp_step  = 8'h40;
    localparam logic [bist_val_width-1:0] ramp_limit = 12'h200;

    localparam int total_frames   = 3 + 12 + 10 + fifo_depth + 2 + 12;
    localparam int timeout_cycles = total_frames * frame_width * 2 * sck_half + 4000;

    logic                      clk;
    logic                      rst_n;
    logic                      inp_sck;
    logic                      inp_ws;
    logic                      inp_sd;
    logic                      rf_i2si_en;
    source_mode_e              rf_src_mode;
    logic [bist_val_width-1:0] rf_bist_start_val;
    logic [bist_inc_width-1:0] rf_bist_inc;
    logic [bist_val_width-1:0] rf_bist_up_limit;
    logic                      i2si_rtr;
    frame_t                    i2si_data;
    logic                      i2si_rts;
    logic                      ro_fifo_overrun;
    logic                      trig_i2si_fifo_overrun_clr;

    logic                      tx_load;
    frame_t                    tx_frame;
    logic                      tx_busy;

    frame_t                    ref_q [$];               // Expected words in pop order
    frame_t                    exp_word;
    logic [15:0]               lfsr_q;
    logic                      idle_check;              // Deserializer disabled phase
    int                        value_errors;
    int                        other_errors;
    int                        cycles;

    i2s_in #(
        .FIFO_DEPTH_LOG2 (fifo_depth_log2),
        .SYNC_STAGES     (sync_stages)
    ) dut0 (
        .clk                        (clk),
        .rst_n                      (rst_n),
        .inp_sck                    (inp_sck),
        .inp_ws                     (inp_ws),
        .inp_sd                     (inp_sd),
        .rf_i2si_en                 (rf_i2si_en),
        .rf_src_mode                (rf_src_mode),
        .rf_bist_start_val          (rf_bist_start_val),
        .rf_bist_inc                (rf_bist_inc),
        .rf_bist_up_limit           (rf_bist_up_limit),
        .i2si_rtr                   (i2si_rtr),
        .i2si_data                  (i2si_data),
        .i2si_rts                   (i2si_rts),
        .ro_fifo_overrun            (ro_fifo_overrun),
        .trig_i2si_fifo_overrun_clr (trig_i2si_fifo_overrun_clr)
    );

    i2s_tx_model #(
        .HALF_PERIOD (sck_half)
    ) u_tx (
        .clk        (clk),
        .load       (tx_load),
        .load_frame (tx_frame),
        .sck        (inp_sck),
        .ws         (inp_ws),
        .sd         (inp_sd),
        .busy       (tx_busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    ////////////////////
    // Helpers
    ////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic frame_t random_frame();
        logic [frame_width-1:0] w;
        w = '0;
        for (int b = 0; b < frame_width; b++)
            w = {w[frame_width-2:0], lfsr_bit()};
        return frame_t'(w);
    endfunction

    task automatic check_level(input string name, input logic expected, input logic actual);
        assert (actual === expected)
        else
        begin
            value_errors++;
            $display("Error: %s expected %h got %h", name, expected, actual);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic send_frames(input int count, input bit expected);
        frame_t f;
        for (int i = 0; i < count; i++)
        begin
            f = random_frame();
            @(negedge clk);
            tx_load  = 1'b1;
            tx_frame = f;
            if (expected)
                ref_q.push_back(f);
        end
        @(negedge clk);
        tx_load = 1'b0;
    endtask

    task automatic wait_tx_done();
        while (!tx_busy)
            @(negedge clk);
        while (tx_busy)
            @(negedge clk);
        repeat (settle_cycles) @(negedge clk);
    endtask

    task automatic wait_drained();
        while (ref_q.size() != 0)
            @(negedge clk);
    endtask

    // The ramp starts at the start value and adds the step until the sum passes the limit
    task automatic expect_ramp(input int count);
        logic [bist_val_width:0]   sum;
        logic [bist_val_width-1:0] val;
        val = ramp_start;
        for (int i = 0; i < count; i++)
        begin
            ref_q.push_back(frame_t'({val, {pad_bits{1'b0}}, val, {pad_bits{1'b0}}}));
            sum = {1'b0, val} + (bist_val_width + 1)'(ramp_step);
            if (sum > {1'b0, ramp_limit})
                val = ramp_start;
            else
                val = sum[bist_val_width-1:0];
        end
    endtask

    ////////////////////
    // Checkers
    ////////////////////

    always @(posedge clk)
    begin
        if (rst_n && i2si_rts && i2si_rtr)
        begin
            assert (ref_q.size() != 0)
            else
            begin
                other_errors++;
                $display("A word was popped while no frame was expected: %h", i2si_data);
            end
            if (ref_q.size() != 0)
            begin
                exp_word = ref_q.pop_front();
                assert (i2si_data == exp_word)
                else
                begin
                    value_errors++;
                    $display("Error: i2si_data expected %h got %h", exp_word, i2si_data);
                end
            end
        end
    end

    idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        idle_check |-> (!i2si_rts && !ro_fifo_overrun))
    else
    begin
        other_errors++;
        $display("Output became active while the deserializer was disabled");
    end

    initial
    begin
        cycles = 0;
        while (cycles < timeout_cycles)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles without finishing", cycles);
        $display("Checks failed");
        $finish;
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial
    begin
        rst_n                      = 1'b0;
        rf_i2si_en                 = 1'b0;
        rf_src_mode                = SRC_SERIAL;
        rf_bist_start_val          = ramp_start;
        rf_bist_inc                = ramp_step;
        rf_bist_up_limit           = ramp_limit;
        i2si_rtr                   = 1'b1;
        trig_i2si_fifo_overrun_clr = 1'b0;
        tx_load                    = 1'b0;
        tx_frame                   = '0;
        lfsr_q                     = 16'd15726;
        idle_check                 = 1'b0;
        value_errors               = 0;
        other_errors               = 0;
        apply_reset();

        // Transmitter runs while the receiver is disabled
        idle_check = 1'b1;
        send_frames(3, 1'b0);
        wait_tx_done();
        idle_check = 1'b0;

        // Serial frames after the dropped partial lead-in
        rf_i2si_en = 1'b1;
        send_frames(12, 1'b1);
        wait_tx_done();
        wait_drained();
        check_level("i2si_rts", 1'b0, i2si_rts);

        // Ramp source from a fresh start
        rf_src_mode = SRC_BIST;
        expect_ramp(10);
        apply_reset();
        wait_drained();
        @(negedge clk);
        i2si_rtr = 1'b0;

        // Back-pressure fills the FIFO and then overruns it
        rf_src_mode = SRC_SERIAL;
        apply_reset();
        send_frames(fifo_depth, 1'b1);
        wait_tx_done();
        check_level("i2si_rts", 1'b1, i2si_rts);
        check_level("ro_fifo_overrun", 1'b0, ro_fifo_overrun);
        send_frames(2, 1'b0);
        wait_tx_done();
        check_level("ro_fifo_overrun", 1'b1, ro_fifo_overrun);
        repeat (20) @(negedge clk);
        check_level("ro_fifo_overrun", 1'b1, ro_fifo_overrun);
        trig_i2si_fifo_overrun_clr = 1'b1;
        @(negedge clk);
        trig_i2si_fifo_overrun_clr = 1'b0;
        check_level("ro_fifo_overrun", 1'b0, ro_fifo_overrun);
        i2si_rtr = 1'b1;
        wait_drained();
        @(negedge clk);
        check_level("i2si_rts", 1'b0, i2si_rts);

        // Random pops while frames arrive
        send_frames(12, 1'b1);
        while (ref_q.size() != 0)
        begin
            @(negedge clk);
            i2si_rtr = lfsr_bit();
        end
        i2si_rtr = 1'b1;
        repeat (settle_cycles) @(negedge clk);         // Last pop lands after the burst ends
        check_level("i2si_rts", 1'b0, i2si_rts);

        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== sim/i2s_tx_model.sv ====
module i2s_tx_model
    import i2si_audio_pkg::*;
#(
    parameter int HALF_PERIOD = 4                       // clk cycles per SCK half
) (
    input  logic   clk,
    input  logic   load,                                // Queue load_frame on this edge
    input  frame_t load_frame,
    output logic   sck,
    output logic   ws,
    output logic   sd,
    output logic   busy                                 // Burst in progress
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int pre_slots = 8;                       // Partial right half before a burst

    frame_t frame_q [$];
    frame_t cur;
    logic   last_lsb;

    always @(posedge clk)
    begin
        if (load)
            frame_q.push_back(load_frame);
    end

    // Data and WS change while SCK is low so the receiver samples them on the rise
    task automatic send_slot(input logic ws_val, input logic sd_val);
        sck = 1'b0;
        ws  = ws_val;
        sd  = sd_val;
        repeat (HALF_PERIOD) @(negedge clk);
        sck = 1'b1;
        repeat (HALF_PERIOD) @(negedge clk);
    endtask

    initial
    begin
        sck  = 1'b0;
        ws   = 1'b0;
        sd   = 1'b0;
        busy = 1'b0;
        @(negedge clk);
        forever
        begin
            if (frame_q.size() == 0)
            begin
                busy = 1'b0;
                send_slot(1'b0, 1'b0);                  // Idle with WS low
            end
            else
            begin
                busy = 1'b1;
                for (int k = 0; k < pre_slots; k++)
                    send_slot(1'b1, frame_q[0].right[k]);
                last_lsb = 1'b0;
                while (frame_q.size() != 0)
                begin
                    cur = frame_q.pop_front();
                    send_slot(1'b0, last_lsb);          // WS falls with previous LSB
                    for (int k = sample_width - 1; k >= 1; k--)
                        send_slot(1'b0, cur.left[k]);
                    send_slot(1'b1, cur.left[0]);
                    for (int k = sample_width - 1; k >= 1; k--)
                        send_slot(1'b1, cur.right[k]);
                    last_lsb = cur.right[0];
                end
                send_slot(1'b0, last_lsb);              // Closing right LSB
            end
        end
    end

endmodule

// ==== verilog/i2s_in.sv ====
module i2s_in
    import i2si_audio_pkg::*;
    import i2si_ctrl_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 3,                  // 8 entries
    parameter int SYNC_STAGES     = 2
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      inp_sck,          // I2S bit clock
    input  logic                      inp_ws,           // Low left, high right
    input  logic                      inp_sd,
    input  logic                      rf_i2si_en,
    input  source_mode_e              rf_src_mode,
    input  logic [bist_val_width-1:0] rf_bist_start_val,
    input  logic [bist_inc_width-1:0] rf_bist_inc,
    input  logic [bist_val_width-1:0] rf_bist_up_limit,
    input  logic                      i2si_rtr,
    output frame_t                    i2si_data,
    output logic                      i2si_rts,
    output logic                      ro_fifo_overrun,
    input  logic                      trig_i2si_fifo_overrun_clr
);

    logic   sck_rise;
    logic   ws_s;
    logic   sd_s;
    frame_t ser_frame;
    logic   ser_valid;
    frame_t bist_frame;
    logic   bist_valid;
    logic   push;
    frame_t push_data;
    logic   fifo_rtr;

    ////////////////////
    // Front end
    ////////////////////

    i2si_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_sync (
        .clk      (clk),
        .rst_n    (rst_n),
        .inp_sck  (inp_sck),
        .inp_ws   (inp_ws),
        .inp_sd   (inp_sd),
        .sck_rise (sck_rise),
        .ws_s     (ws_s),
        .sd_s     (sd_s)
    );

    i2si_deserializer u_deser (
        .clk       (clk),
        .rst_n     (rst_n),
        .sck_rise  (sck_rise),
        .ws_s      (ws_s),
        .sd_s      (sd_s),
        .i2si_en   (rf_i2si_en),
        .ser_frame (ser_frame),
        .ser_valid (ser_valid)
    );

    i2si_bist_gen u_bist (
        .clk            (clk),
        .rst_n          (rst_n),
        .sck_rise       (sck_rise),
        .bist_start_val (rf_bist_start_val),
        .bist_inc       (rf_bist_inc),
        .bist_up_limit  (rf_bist_up_limit),
        .bist_frame     (bist_frame),
        .bist_valid     (bist_valid)
    );

    ////////////////////
    // Merge and FIFO
    ////////////////////

    i2si_merge u_merge (
        .clk              (clk),
        .rst_n            (rst_n),
        .src_mode         (rf_src_mode),
        .ser_frame        (ser_frame),
        .ser_valid        (ser_valid),
        .bist_frame       (bist_frame),
        .bist_valid       (bist_valid),
        .fifo_rtr         (fifo_rtr),
        .push             (push),
        .push_data        (push_data),
        .trig_overrun_clr (trig_i2si_fifo_overrun_clr),
        .overrun          (ro_fifo_overrun)
    );

    i2si_fifo #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) u_fifo (
        .clk           (clk),
        .rst_n         (rst_n),
        .fifo_inp_data (push_data),
        .fifo_inp_rts  (push),
        .fifo_inp_rtr  (fifo_rtr),
        .fifo_out_data (i2si_data),
        .fifo_out_rts  (i2si_rts),
        .fifo_out_rtr  (i2si_rtr)
    );

endmodule

// ==== verilog/i2si_fifo.sv ====
module i2si_fifo
    import i2si_audio_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 3
) (
    input  logic   clk,
    input  logic   rst_n,
    input  frame_t fifo_inp_data,
    input  logic   fifo_inp_rts,                        // Write request
    output logic   fifo_inp_rtr,                        // Not full
    output frame_t fifo_out_data,                       // Head entry
    output logic   fifo_out_rts,                        // Not empty
    input  logic   fifo_out_rtr
);

    localparam int depth = 2 ** FIFO_DEPTH_LOG2;

    frame_t                   mem [depth];
    logic [FIFO_DEPTH_LOG2:0] wr_ptr;                   // Extra MSB tells full from empty
    logic [FIFO_DEPTH_LOG2:0] rd_ptr;
    logic                     full;
    logic                     empty;
    logic                     do_push;
    logic                     do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_DEPTH_LOG2] != rd_ptr[FIFO_DEPTH_LOG2]) &&
                   (wr_ptr[FIFO_DEPTH_LOG2-1:0] == rd_ptr[FIFO_DEPTH_LOG2-1:0]);

    assign fifo_inp_rtr  = ~full;
    assign fifo_out_rts  = ~empty;
    assign fifo_out_data = mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];

    assign do_push = fifo_inp_rts & fifo_inp_rtr;
    assign do_pop  = fifo_out_rts & fifo_out_rtr;

    ////////////////////
    // Pointers
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= fifo_inp_data;
    end

endmodule

// ==== verilog/i2si_merge.sv ====
module i2si_merge
    import i2si_audio_pkg::*;
    import i2si_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  source_mode_e src_mode,
    input  frame_t       ser_frame,
    input  logic         ser_valid,
    input  frame_t       bist_frame,
    input  logic         bist_valid,
    input  logic         fifo_rtr,
    output logic         push,
    output frame_t       push_data,
    input  logic         trig_overrun_clr,
    output logic         overrun
);

    logic sel_valid;

    always_comb
    begin
        if (src_mode == SRC_BIST)
        begin
            sel_valid = bist_valid;
            push_data = bist_frame;
        end
        else
        begin
            sel_valid = ser_valid;
            push_data = ser_frame;
        end
    end

    assign push = sel_valid & fifo_rtr;                 // Dropped when FIFO is full

    // Sticky flag where a set beats a clear
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            overrun <= 1'b0;
        else if (sel_valid && !fifo_rtr)
            overrun <= 1'b1;
        else if (trig_overrun_clr)
            overrun <= 1'b0;
    end

endmodule

// ==== bist/i2si_bist_gen.sv ====
module i2si_bist_gen
    import i2si_audio_pkg::*;
    import i2si_ctrl_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      sck_rise,
    input  logic [bist_val_width-1:0] bist_start_val,
    input  logic [bist_inc_width-1:0] bist_inc,
    input  logic [bist_val_width-1:0] bist_up_limit,
    output frame_t                    bist_frame,
    output logic                      bist_valid
);

    localparam int tick_width = $clog2(frame_width);   // SCK per frame
    localparam int sum_width  = bist_val_width + 1;
    localparam int pad_width  = sample_width - bist_val_width;

    logic [tick_width-1:0]     sck_cnt;
    logic                      frame_tick;
    logic                      ramp_started;           // Low until the first frame is out
    logic [bist_val_width-1:0] ramp_val;
    logic [bist_val_width-1:0] cur_val;
    logic [sum_width-1:0]      ramp_sum;

    assign frame_tick = sck_rise && (sck_cnt == {tick_width{1'b1}});
    assign cur_val    = ramp_started ? ramp_val : bist_start_val;
    assign ramp_sum   = {1'b0, cur_val} + sum_width'(bist_inc);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sck_cnt      <= '0;
            ramp_started <= 1'b0;
            ramp_val     <= '0;
            bist_valid   <= 1'b0;
        end
        else
        begin
            if (sck_rise)
                sck_cnt <= sck_cnt + 1'b1;      // Wraps once per frame
            if (frame_tick)
            begin
                ramp_started <= 1'b1;
                if (ramp_sum > sum_width'(bist_up_limit))
                    ramp_val <= bist_start_val; // Restart once past the limit
                else
                    ramp_val <= ramp_sum[bist_val_width-1:0];
            end
            bist_valid <= frame_tick;
        end
    end

    // Same left justified value on both channels
    always_ff @(posedge clk)
    begin
        if (frame_tick)
        begin
            bist_frame.left  <= {cur_val, {pad_width{1'b0}}};
            bist_frame.right <= {cur_val, {pad_width{1'b0}}};
        end
    end

endmodule

// ==== deserializer/i2si_deserializer.sv ====
module i2si_deserializer
    import i2si_audio_pkg::*;
    import i2si_ctrl_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   sck_rise,
    input  logic   ws_s,
    input  logic   sd_s,
    input  logic   i2si_en,
    output frame_t ser_frame,
    output logic   ser_valid
);

    localparam int cnt_width = $clog2(sample_width + 1);

    deser_state_e            state;
    logic                    ws_prev;                   // WS at the previous SCK rise
    logic                    ws_edge;
    logic                    ch_right;                  // Channel the next bits belong to
    logic [cnt_width-1:0]    bit_cnt;                   // Bits taken in this half-frame
    logic                    take_bit;
    logic                    last_bit;
    logic [sample_width-1:0] left_sr;
    logic [sample_width-1:0] right_sr;

    assign ws_edge  = sck_rise && (ws_s != ws_prev);
    assign take_bit = sck_rise && (state == DS_RUN) && (bit_cnt < cnt_width'(sample_width));
    assign last_bit = take_bit && ch_right && (bit_cnt == cnt_width'(sample_width - 1));

    ////////////////////
    // Frame FSM
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= DS_IDLE;
        else if (!i2si_en)
            state <= DS_IDLE;
        else
        begin
            case (state)
                DS_IDLE:    state <= DS_WAIT_WS;
                DS_WAIT_WS:
                begin
                    if (sck_rise && ws_prev && !ws_s)   // WS high to low starts a frame
                        state <= DS_RUN;
                end
                DS_RUN:     state <= DS_RUN;
                default:    state <= DS_IDLE;
            endcase
        end
    end

    ////////////////////
    // Bit counter and channel
    ////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ws_prev  <= 1'b0;
            bit_cnt  <= '0;
            ch_right <= 1'b0;
            ser_valid <= 1'b0;
        end
        else
        begin
            if (sck_rise)
                ws_prev <= ws_s;
            // The bit on the WS change rise is still the previous word's LSB
            if (ws_edge)
            begin
                bit_cnt  <= '0;
                ch_right <= ws_s;
            end
            else if (take_bit)
                bit_cnt <= bit_cnt + 1'b1;
            ser_valid <= last_bit;
        end
    end

    // MSB first shift into the current channel
    always_ff @(posedge clk)
    begin
        if (take_bit)
        begin
            if (ch_right)
                right_sr <= {right_sr[sample_width-2:0], sd_s};
            else
                left_sr <= {left_sr[sample_width-2:0], sd_s};
        end
        if (last_bit)
        begin
            ser_frame.left  <= left_sr;
            ser_frame.right <= {right_sr[sample_width-2:0], sd_s};
        end
    end

endmodule

// ==== verilog/i2si_sync.sv ====
module i2si_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic clk,
    input  logic rst_n,
    input  logic inp_sck,
    input  logic inp_ws,
    input  logic inp_sd,
    output logic sck_rise,                              // One clk per SCK rising edge
    output logic ws_s,
    output logic sd_s
);

    // One chain carries {sck, ws, sd} so all three see the same delay
    logic [2:0] sync_q [SYNC_STAGES];
    logic       sck_d;                                  // Previous synchronized SCK

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < SYNC_STAGES; i++)
            begin
                sync_q[i] <= '0;
            end
            sck_d <= 1'b0;
        end
        else
        begin
            sync_q[0] <= {inp_sck, inp_ws, inp_sd};
            for (int i = 1; i < SYNC_STAGES; i++)
            begin
                sync_q[i] <= sync_q[i-1];
            end
            sck_d <= sync_q[SYNC_STAGES-1][2];
        end
    end

    assign sck_rise = sync_q[SYNC_STAGES-1][2] & ~sck_d;
    assign ws_s     = sync_q[SYNC_STAGES-1][1];         // Aligned with sck_rise
    assign sd_s     = sync_q[SYNC_STAGES-1][0];

endmodule

// ==== common/i2si_ctrl_pkg.sv ====
package i2si_ctrl_pkg;

    typedef enum logic {
        SRC_SERIAL = 1'b0,                              // Deserialized I2S input
        SRC_BIST   = 1'b1                               // Ramp generator
    } source_mode_e;

    typedef enum logic [1:0] {
        DS_IDLE    = 2'd0,                              // Disabled
        DS_WAIT_WS = 2'd1,                              // Looking for first left word
        DS_RUN     = 2'd2                               // Capturing frames
    } deser_state_e;

    parameter int bist_val_width = 12;                  // Ramp value and limits
    parameter int bist_inc_width = 8;                   // Ramp step

endpackage

// ==== common/i2si_audio_pkg.sv ====
package i2si_audio_pkg;

    ////////////////////
    // Sample and frame sizes
    ////////////////////

    parameter int sample_width = 16;                    // Bits per audio channel
    parameter int frame_width  = 2 * sample_width;      // Left plus right

    ////////////////////
    // Frame word layout
    ////////////////////

    // Left channel sits in the upper half of the word
    typedef struct packed {
        logic [sample_width-1:0] left;                  // Bits 31:16
        logic [sample_width-1:0] right;                 // Bits 15:0
    } frame_t;

endpackage
